// ==== list.f ====
hdl/noc_pkg.sv
hdl/noc_flit_fifo.sv
hdl/noc_output_arbiter.sv
hdl/noc_router.sv
hdl/noc_fabric.sv
dv/noc_fabric_props.sv
dv/noc_fabric_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile the mesh testbench with Verilator, run it and look for the pass line.
set -e
cd "$(dirname "$0")"

verilator --binary --assert --top-module noc_fabric_tb -f list.f -o noc_fabric_sim

# Assertion failures are counted by the testbench, so the run goes on after one.
sim_output=$(./obj_dir/noc_fabric_sim +verilator+error+limit+1000)
echo "$sim_output"

if echo "$sim_output" | grep -qx "all tests passed"; then
  exit 0
fi
exit 1

// ==== dv/noc_fabric_tb.sv ====
`timescale 1ns/1ps

module noc_fabric_tb;

  localparam int NODES          = noc_pkg::NUM_NODES;
  localparam int RANDOM_PACKETS = 6;
  localparam int BURST_PACKETS  = 2;
  localparam int HOLD_NODE      = 8;
  localparam int HOT_NODE       = 4;
  localparam int HOLD_CYCLES    = 50;
  localparam int TOTAL_PACKETS  = 1 + NODES * (RANDOM_PACKETS + 2 * BURST_PACKETS);
  localparam int WORST_PATH     = 2 * (noc_pkg::SIZE_X + noc_pkg::SIZE_Y - 1) + 3;
  localparam int STALL_MARGIN   = 8;
  localparam int DRAIN_CYCLES   = NODES * WORST_PATH * STALL_MARGIN;
  localparam int TIMEOUT_CYCLES = 16 + HOLD_CYCLES + TOTAL_PACKETS * WORST_PATH * STALL_MARGIN;

  logic               clk;
  logic               rst_i;
  noc_pkg::noc_flit_t flit_i [NODES];
  logic [NODES-1:0]   valid_i;
  logic [NODES-1:0]   ready_o;
  noc_pkg::noc_flit_t flit_o [NODES];
  logic [NODES-1:0]   valid_o;
  logic [NODES-1:0]   ready_i;

  noc_pkg::noc_flit_t tx_q  [NODES][$];          // Flits waiting per source.
  noc_pkg::noc_flit_t exp_q [NODES * NODES][$];  // Indexed by src * NODES + dst.
  int   tag_cnt   [NODES];
  logic rx_in_pkt [NODES];
  int   rx_src    [NODES];
  int   outstanding;
  int   ready_mode;  // 0 open, 1 random, 2 one node held.
  int   seed;
  int   mismatch_count;
  int   other_errors;

  noc_fabric u_dut (
    .clk     (clk),
    .rst_i   (rst_i),
    .flit_i  (flit_i),
    .valid_i (valid_i),
    .ready_o (ready_o),
    .flit_o  (flit_o),
    .valid_o (valid_o),
    .ready_i (ready_i)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  function automatic logic [31:0] payload_word(input int src, input int tag, input int idx);
    return {4'(src), 20'(tag), 8'(idx)};
  endfunction

  function automatic int assertion_failures();
    return u_dut.u_props.stability_failures + u_dut.u_props.reset_failures
         + u_dut.u_props.route_failures + u_dut.u_props.order_failures;
  endfunction

  function automatic logic sources_empty();
    logic empty;
    empty = 1'b1;
    for (int n = 0; n < NODES; n++) begin
      if (tx_q[n].size() != 0) begin
        empty = 1'b0;
      end
    end
    return empty;
  endfunction

  task automatic flag_mismatch(input string msg);
    $display("MISMATCH at %0t ns: %s", $time, msg);
    mismatch_count++;
  endtask

  task automatic queue_packet(input int src, input int dst, input int n_payload);
    noc_pkg::noc_flit_t f;
    f                      = '0;
    f.flit_type            = noc_pkg::FLIT_HEADER;
    f.tail                 = n_payload == 0;
    f.data.header.dst_x    = noc_pkg::noc_id_x_t'(dst % noc_pkg::SIZE_X);
    f.data.header.dst_y    = noc_pkg::noc_id_y_t'(dst / noc_pkg::SIZE_X);
    f.data.header.src_x    = noc_pkg::noc_id_x_t'(src % noc_pkg::SIZE_X);
    f.data.header.src_y    = noc_pkg::noc_id_y_t'(src / noc_pkg::SIZE_X);
    f.data.header.tag      = noc_pkg::TAG_WIDTH'(tag_cnt[src]);
    tx_q[src].push_back(f);
    exp_q[src * NODES + dst].push_back(f);
    for (int i = 0; i < n_payload; i++) begin
      f.flit_type    = noc_pkg::FLIT_PAYLOAD;
      f.tail         = i == n_payload - 1;
      f.data.raw     = payload_word(src, tag_cnt[src], i);
      tx_q[src].push_back(f);
      exp_q[src * NODES + dst].push_back(f);
    end
    outstanding += n_payload + 1;
    tag_cnt[src]++;
  endtask

  // Scoreboard for one flit leaving a local output.
  task automatic check_output(input int node, input noc_pkg::noc_flit_t f);
    int                 src;
    noc_pkg::noc_flit_t want;
    if (f.flit_type == noc_pkg::FLIT_HEADER) begin
      assert (!rx_in_pkt[node])
        else flag_mismatch($sformatf("node %0d got a header inside a packet", node));
      assert (int'(f.data.header.dst_y) * noc_pkg::SIZE_X + int'(f.data.header.dst_x) == node)
        else flag_mismatch($sformatf("node %0d got a header for another node", node));
      src          = int'(f.data.header.src_y) * noc_pkg::SIZE_X + int'(f.data.header.src_x);
      rx_src[node] = src;
    end else begin
      assert (rx_in_pkt[node])
        else flag_mismatch($sformatf("node %0d got a payload without header", node));
      src = rx_src[node];
    end
    rx_in_pkt[node] = !f.tail;
    assert (src < NODES && exp_q[src * NODES + node].size() != 0)
      else flag_mismatch($sformatf("node %0d got an unexpected flit %h", node, f));
    if (src < NODES && exp_q[src * NODES + node].size() != 0) begin
      want = exp_q[src * NODES + node].pop_front();
      assert (f == want)
        else flag_mismatch($sformatf("node %0d got %h, expected %h", node, f, want));
      outstanding--;
    end
  endtask

  // Gives up once the sources are empty and nothing more arrives in time.
  task automatic wait_drained();
    int drain;
    drain = 0;
    while (outstanding != 0 && drain < DRAIN_CYCLES) begin
      @(negedge clk);
      if (sources_empty()) begin
        drain++;
      end
    end
    repeat (4) @(negedge clk);
  endtask

  // ##########################################################################
  // Port driver and output monitor on the falling edge.
  // ##########################################################################
  initial begin : port_driver
    forever begin
      @(negedge clk);
      for (int n = 0; n < NODES; n++) begin
        valid_i[n] = !rst_i && tx_q[n].size() != 0;
        flit_i[n]  = (tx_q[n].size() != 0) ? tx_q[n][0] : '0;
        if (ready_mode == 1) begin
          ready_i[n] = ($random(seed) & 3) != 0;
        end else begin
          ready_i[n] = !(ready_mode == 2 && n == HOLD_NODE);
        end
      end
      #1;
      for (int n = 0; n < NODES; n++) begin
        if (valid_i[n] && ready_o[n]) begin
          void'(tx_q[n].pop_front());  // Taken at the next rising edge.
        end
        if (valid_o[n] && ready_i[n]) begin
          check_output(n, flit_o[n]);
        end
      end
    end
  end

  initial begin : watchdog
    repeat (TIMEOUT_CYCLES) @(posedge clk);
    $display("Timeout: traffic did not drain, %0d flits still outstanding", outstanding);
    $display("Summary: %0d mismatches, %0d assertion failures, %0d other errors",
             mismatch_count, assertion_failures(), other_errors + 1);
    $display("tests failed");
    $finish;
  end

  initial begin : main_flow
    int leftover;
    seed           = 10531;
    rst_i          = 1'b1;
    valid_i        = '0;
    ready_i        = '1;
    ready_mode     = 0;
    outstanding    = 0;
    mismatch_count = 0;
    other_errors   = 0;
    leftover       = 0;
    for (int n = 0; n < NODES; n++) begin
      flit_i[n]    = '0;
      tag_cnt[n]   = 0;
      rx_in_pkt[n] = 1'b0;
      rx_src[n]    = 0;
    end
    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_i = 1'b0;

    queue_packet(0, 1, 1);  // Single hop to the east neighbor.
    wait_drained();

    ready_mode = 1;
    for (int p = 0; p < RANDOM_PACKETS; p++) begin
      for (int n = 0; n < NODES; n++) begin
        queue_packet(n, int'($unsigned($random(seed)) % NODES),
                     int'($unsigned($random(seed)) % 4));
      end
    end
    wait_drained();

    // One output held low long enough to back up the mesh.
    ready_mode = 2;
    for (int p = 0; p < BURST_PACKETS; p++) begin
      for (int n = 0; n < NODES; n++) begin
        queue_packet(n, HOLD_NODE, 3);
      end
    end
    repeat (HOLD_CYCLES) @(negedge clk);
    ready_mode = 0;
    wait_drained();

    for (int p = 0; p < BURST_PACKETS; p++) begin
      for (int n = 0; n < NODES; n++) begin
        queue_packet(n, HOT_NODE, 3);
      end
    end
    wait_drained();

    for (int k = 0; k < NODES * NODES; k++) begin
      leftover += exp_q[k].size();
    end
    assert (leftover == 0) else begin
      $display("Error: %0d expected flits were never delivered", leftover);
      other_errors++;
    end
    $display("Summary: %0d mismatches, %0d assertion failures, %0d other errors",
             mismatch_count, assertion_failures(), other_errors);
    if (mismatch_count == 0 && assertion_failures() == 0 && other_errors == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

endmodule

// ==== dv/noc_fabric_props.sv ====
`timescale 1ns/1ps

module noc_fabric_props (
  input logic                          clk,
  input logic                          rst_i,
  input noc_pkg::noc_flit_t            out_flit_i  [noc_pkg::NUM_NODES],
  input logic [noc_pkg::NUM_NODES-1:0] out_valid_i,
  input logic [noc_pkg::NUM_NODES-1:0] out_ready_i
);

  noc_pkg::noc_flit_t            flit_prev [noc_pkg::NUM_NODES];
  logic [noc_pkg::NUM_NODES-1:0] stall_q;   // Valid without ready last cycle.
  logic [noc_pkg::NUM_NODES-1:0] in_pkt_q;  // Between header and tail.
  logic [noc_pkg::NUM_NODES-1:0] hold_ok;
  logic [noc_pkg::NUM_NODES-1:0] route_ok;
  logic [noc_pkg::NUM_NODES-1:0] order_ok;
  int stability_failures = 0;
  int reset_failures     = 0;
  int route_failures     = 0;
  int order_failures     = 0;

  always_ff @(posedge clk) begin
    flit_prev <= out_flit_i;
    if (rst_i) begin
      stall_q  <= '0;
      in_pkt_q <= '0;
    end else begin
      stall_q <= out_valid_i & ~out_ready_i;
      for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
        if (out_valid_i[n] && out_ready_i[n]) begin
          in_pkt_q[n] <= !out_flit_i[n].tail;
        end
      end
    end
  end

  always_comb begin
    for (int n = 0; n < noc_pkg::NUM_NODES; n++) begin
      hold_ok[n]  = !stall_q[n] || (out_valid_i[n] && out_flit_i[n] == flit_prev[n]);
      route_ok[n] = !out_valid_i[n] || out_flit_i[n].flit_type != noc_pkg::FLIT_HEADER ||
                    (out_flit_i[n].data.header.dst_x == noc_pkg::noc_id_x_t'(n % noc_pkg::SIZE_X)
                  && out_flit_i[n].data.header.dst_y == noc_pkg::noc_id_y_t'(n / noc_pkg::SIZE_X));
      order_ok[n] = !(out_valid_i[n] && out_ready_i[n]) ||
                    ((out_flit_i[n].flit_type == noc_pkg::FLIT_HEADER) != in_pkt_q[n]);
    end
  end

  // ##########################################################################
  // Local output checks.
  // ##########################################################################
  a_hold_stable: assert property (@(posedge clk) disable iff (rst_i) &hold_ok)
    else begin
      stability_failures++;
      $error("Stalled local output changed or dropped");
    end
  a_reset_idle: assert property (@(posedge clk) rst_i |=> out_valid_i == '0)
    else begin
      reset_failures++;
      $error("Local output valid high after reset");
    end
  a_route_dest: assert property (@(posedge clk) disable iff (rst_i) &route_ok)
    else begin
      route_failures++;
      $error("Header left at the wrong node");
    end
  a_wormhole: assert property (@(posedge clk) disable iff (rst_i) &order_ok)
    else begin
      order_failures++;
      $error("Header and payload out of packet order");
    end

endmodule

bind noc_fabric noc_fabric_props u_props (
  .clk         (clk),
  .rst_i       (rst_i),
  .out_flit_i  (flit_o),
  .out_valid_i (valid_o),
  .out_ready_i (ready_i)
);

// ==== hdl/noc_fabric.sv ====
`timescale 1ns/1ps

module noc_fabric (
  input  logic                          clk,
  input  logic                          rst_i,
  input  noc_pkg::noc_flit_t            flit_i  [noc_pkg::NUM_NODES],
  input  logic [noc_pkg::NUM_NODES-1:0] valid_i,
  output logic [noc_pkg::NUM_NODES-1:0] ready_o,
  output noc_pkg::noc_flit_t            flit_o  [noc_pkg::NUM_NODES],
  output logic [noc_pkg::NUM_NODES-1:0] valid_o,
  input  logic [noc_pkg::NUM_NODES-1:0] ready_i
);

  noc_pkg::noc_flit_t            r_in_flit   [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] r_in_valid  [noc_pkg::NUM_NODES];
  logic [noc_pkg::NUM_PORTS-1:0] r_in_ready  [noc_pkg::NUM_NODES];
  noc_pkg::noc_flit_t            r_out_flit  [noc_pkg::NUM_NODES][noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] r_out_valid [noc_pkg::NUM_NODES];
  logic [noc_pkg::NUM_PORTS-1:0] r_out_ready [noc_pkg::NUM_NODES];

  for (genvar g_node = 0; g_node < noc_pkg::NUM_NODES; g_node++) begin : g_router
    noc_router #(
      .ID_X (noc_pkg::noc_id_x_t'(g_node % noc_pkg::SIZE_X)),
      .ID_Y (noc_pkg::noc_id_y_t'(g_node / noc_pkg::SIZE_X))
    ) u_router (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_flit_i   (r_in_flit[g_node]),
      .in_valid_i  (r_in_valid[g_node]),
      .in_ready_o  (r_in_ready[g_node]),
      .out_flit_o  (r_out_flit[g_node]),
      .out_valid_o (r_out_valid[g_node]),
      .out_ready_i (r_out_ready[g_node])
    );

    // ########################################################################
    // Local port.
    // ########################################################################
    assign r_in_flit[g_node][noc_pkg::PORT_LOCAL]   = flit_i[g_node];
    assign r_in_valid[g_node][noc_pkg::PORT_LOCAL]  = valid_i[g_node];
    assign ready_o[g_node]                          = r_in_ready[g_node][noc_pkg::PORT_LOCAL];
    assign flit_o[g_node]                           = r_out_flit[g_node][noc_pkg::PORT_LOCAL];
    assign valid_o[g_node]                          = r_out_valid[g_node][noc_pkg::PORT_LOCAL];
    assign r_out_ready[g_node][noc_pkg::PORT_LOCAL] = ready_i[g_node];

    // ########################################################################
    // Mesh links. Each router wires its own inputs and output readies.
    // ########################################################################
    if (g_node % noc_pkg::SIZE_X != noc_pkg::SIZE_X - 1) begin : g_east
      assign r_in_flit[g_node][noc_pkg::PORT_EAST]   = r_out_flit[g_node+1][noc_pkg::PORT_WEST];
      assign r_in_valid[g_node][noc_pkg::PORT_EAST]  = r_out_valid[g_node+1][noc_pkg::PORT_WEST];
      assign r_out_ready[g_node][noc_pkg::PORT_EAST] = r_in_ready[g_node+1][noc_pkg::PORT_WEST];
    end else begin : g_east_edge
      assign r_in_flit[g_node][noc_pkg::PORT_EAST]   = '0;
      assign r_in_valid[g_node][noc_pkg::PORT_EAST]  = 1'b0;
      assign r_out_ready[g_node][noc_pkg::PORT_EAST] = 1'b1;
    end

    if (g_node % noc_pkg::SIZE_X != 0) begin : g_west
      assign r_in_flit[g_node][noc_pkg::PORT_WEST]   = r_out_flit[g_node-1][noc_pkg::PORT_EAST];
      assign r_in_valid[g_node][noc_pkg::PORT_WEST]  = r_out_valid[g_node-1][noc_pkg::PORT_EAST];
      assign r_out_ready[g_node][noc_pkg::PORT_WEST] = r_in_ready[g_node-1][noc_pkg::PORT_EAST];
    end else begin : g_west_edge
      assign r_in_flit[g_node][noc_pkg::PORT_WEST]   = '0;
      assign r_in_valid[g_node][noc_pkg::PORT_WEST]  = 1'b0;
      assign r_out_ready[g_node][noc_pkg::PORT_WEST] = 1'b1;
    end

    if (g_node / noc_pkg::SIZE_X != noc_pkg::SIZE_Y - 1) begin : g_north
      assign r_in_flit[g_node][noc_pkg::PORT_NORTH] =
        r_out_flit[g_node+noc_pkg::SIZE_X][noc_pkg::PORT_SOUTH];
      assign r_in_valid[g_node][noc_pkg::PORT_NORTH] =
        r_out_valid[g_node+noc_pkg::SIZE_X][noc_pkg::PORT_SOUTH];
      assign r_out_ready[g_node][noc_pkg::PORT_NORTH] =
        r_in_ready[g_node+noc_pkg::SIZE_X][noc_pkg::PORT_SOUTH];
    end else begin : g_north_edge
      assign r_in_flit[g_node][noc_pkg::PORT_NORTH]   = '0;
      assign r_in_valid[g_node][noc_pkg::PORT_NORTH]  = 1'b0;
      assign r_out_ready[g_node][noc_pkg::PORT_NORTH] = 1'b1;
    end

    if (g_node / noc_pkg::SIZE_X != 0) begin : g_south
      assign r_in_flit[g_node][noc_pkg::PORT_SOUTH] =
        r_out_flit[g_node-noc_pkg::SIZE_X][noc_pkg::PORT_NORTH];
      assign r_in_valid[g_node][noc_pkg::PORT_SOUTH] =
        r_out_valid[g_node-noc_pkg::SIZE_X][noc_pkg::PORT_NORTH];
      assign r_out_ready[g_node][noc_pkg::PORT_SOUTH] =
        r_in_ready[g_node-noc_pkg::SIZE_X][noc_pkg::PORT_NORTH];
    end else begin : g_south_edge
      assign r_in_flit[g_node][noc_pkg::PORT_SOUTH]   = '0;
      assign r_in_valid[g_node][noc_pkg::PORT_SOUTH]  = 1'b0;
      assign r_out_ready[g_node][noc_pkg::PORT_SOUTH] = 1'b1;
    end
  end

endmodule

// ==== hdl/noc_router.sv ====
`timescale 1ns/1ps

module noc_router #(
  parameter noc_pkg::noc_id_x_t ID_X = '0,
  parameter noc_pkg::noc_id_y_t ID_Y = '0
) (
  input  logic                          clk,
  input  logic                          rst_i,
  input  noc_pkg::noc_flit_t            in_flit_i   [noc_pkg::NUM_PORTS],
  input  logic [noc_pkg::NUM_PORTS-1:0] in_valid_i,
  output logic [noc_pkg::NUM_PORTS-1:0] in_ready_o,
  output noc_pkg::noc_flit_t            out_flit_o  [noc_pkg::NUM_PORTS],
  output logic [noc_pkg::NUM_PORTS-1:0] out_valid_o,
  input  logic [noc_pkg::NUM_PORTS-1:0] out_ready_i
);

  noc_pkg::noc_flit_t            fifo_flit  [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] fifo_valid;
  logic [noc_pkg::NUM_PORTS-1:0] fifo_pop;
  logic [noc_pkg::NUM_PORTS-1:0] is_header;

  noc_pkg::noc_port_idx_t        route_calc [noc_pkg::NUM_PORTS];
  noc_pkg::noc_port_idx_t        route_sel  [noc_pkg::NUM_PORTS];
  noc_pkg::noc_port_idx_t        route_q    [noc_pkg::NUM_PORTS];

  // Indexed by output with one bit per input.
  logic [noc_pkg::NUM_PORTS-1:0] req        [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] grant      [noc_pkg::NUM_PORTS];
  logic [noc_pkg::NUM_PORTS-1:0] out_free;
  logic [noc_pkg::NUM_PORTS-1:0] move;
  noc_pkg::noc_flit_t            xbar_flit  [noc_pkg::NUM_PORTS];

  // XY order. X is resolved before Y.
  function automatic noc_pkg::noc_port_idx_t xy_route(input noc_pkg::noc_header_t hdr);
    noc_pkg::noc_port_idx_t port;
    if (hdr.dst_x > ID_X) begin
      port = noc_pkg::PORT_EAST;
    end else if (hdr.dst_x < ID_X) begin
      port = noc_pkg::PORT_WEST;
    end else if (hdr.dst_y > ID_Y) begin
      port = noc_pkg::PORT_NORTH;
    end else if (hdr.dst_y < ID_Y) begin
      port = noc_pkg::PORT_SOUTH;
    end else begin
      port = noc_pkg::PORT_LOCAL;
    end
    return port;
  endfunction

  // ##########################################################################
  // Input FIFOs and output arbiters.
  // ##########################################################################
  for (genvar g_port = 0; g_port < noc_pkg::NUM_PORTS; g_port++) begin : g_port_slice
    noc_flit_fifo u_fifo (
      .clk         (clk),
      .rst_i       (rst_i),
      .in_flit_i   (in_flit_i[g_port]),
      .in_valid_i  (in_valid_i[g_port]),
      .in_ready_o  (in_ready_o[g_port]),
      .out_flit_o  (fifo_flit[g_port]),
      .out_valid_o (fifo_valid[g_port]),
      .out_ready_i (fifo_pop[g_port])
    );

    noc_output_arbiter u_arbiter (
      .clk        (clk),
      .rst_i      (rst_i),
      .request_i  (req[g_port]),
      .header_i   (is_header),
      .transfer_i (move[g_port]),
      .tail_i     (xbar_flit[g_port].tail),
      .grant_o    (grant[g_port])
    );
  end

  // ##########################################################################
  // Route computation.
  // ##########################################################################
  always_comb begin
    for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
      is_header[i]  = fifo_flit[i].flit_type == noc_pkg::FLIT_HEADER;
      route_calc[i] = xy_route(fifo_flit[i].data.header);
      route_sel[i]  = is_header[i] ? route_calc[i] : route_q[i];  // Payloads follow.
    end
  end

  always_comb begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        req[o][i] = fifo_valid[i] && (route_sel[i] == noc_pkg::noc_port_idx_t'(o));
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        route_q[i] <= noc_pkg::PORT_LOCAL;
      end
    end else begin
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (fifo_pop[i] && is_header[i]) begin
          route_q[i] <= route_calc[i];
        end
      end
    end
  end

  // ##########################################################################
  // Crossbar and output registers.
  // ##########################################################################
  always_comb begin
    fifo_pop = '0;
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      out_free[o]  = !out_valid_o[o] || out_ready_i[o];  // Empty or draining.
      move[o]      = out_free[o] && |(grant[o] & req[o]);
      xbar_flit[o] = '0;
      for (int i = 0; i < noc_pkg::NUM_PORTS; i++) begin
        if (grant[o][i]) begin
          xbar_flit[o] = fifo_flit[i];
        end
        if (grant[o][i] && req[o][i] && out_free[o]) begin
          fifo_pop[i] = 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
      if (move[o]) begin
        out_flit_o[o] <= xbar_flit[o];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_valid_o <= '0;
    end else begin
      for (int o = 0; o < noc_pkg::NUM_PORTS; o++) begin
        if (move[o]) begin
          out_valid_o[o] <= 1'b1;
        end else if (out_ready_i[o]) begin
          out_valid_o[o] <= 1'b0;
        end
      end
    end
  end

endmodule

// ==== hdl/noc_output_arbiter.sv ====
`timescale 1ns/1ps

module noc_output_arbiter (
  input  logic                          clk,
  input  logic                          rst_i,
  input  logic [noc_pkg::NUM_PORTS-1:0] request_i,
  input  logic [noc_pkg::NUM_PORTS-1:0] header_i,
  input  logic                          transfer_i,
  input  logic                          tail_i,
  output logic [noc_pkg::NUM_PORTS-1:0] grant_o
);

  logic                  lock_q;
  noc_pkg::noc_port_idx_t win_q;     // Input holding the lock.
  noc_pkg::noc_port_idx_t last_q;    // Search starts after the last winner.
  noc_pkg::noc_port_idx_t pick;
  logic                  pick_valid;

  // Round-robin search over header requests.
  always_comb begin : rr_search
    int idx;
    pick       = last_q;
    pick_valid = 1'b0;
    for (int i = 1; i <= noc_pkg::NUM_PORTS; i++) begin
      idx = (int'(last_q) + i) % noc_pkg::NUM_PORTS;
      if (!pick_valid && request_i[idx] && header_i[idx]) begin
        pick       = noc_pkg::noc_port_idx_t'(idx);
        pick_valid = 1'b1;
      end
    end
  end

  always_comb begin
    grant_o = '0;
    if (lock_q) begin
      grant_o[win_q] = 1'b1;
    end else if (pick_valid) begin
      grant_o[pick] = 1'b1;  // Same cycle as the request.
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      lock_q <= 1'b0;
      win_q  <= noc_pkg::PORT_LOCAL;
      last_q <= noc_pkg::noc_port_idx_t'(noc_pkg::NUM_PORTS - 1);
    end else if (transfer_i && tail_i) begin
      // Single-flit packets never take the lock.
      lock_q <= 1'b0;
      last_q <= lock_q ? win_q : pick;
    end else if (!lock_q && pick_valid) begin
      lock_q <= 1'b1;
      win_q  <= pick;
    end
  end

endmodule

// ==== hdl/noc_flit_fifo.sv ====
`timescale 1ns/1ps

module noc_flit_fifo (
  input  logic               clk,
  input  logic               rst_i,
  input  noc_pkg::noc_flit_t in_flit_i,
  input  logic               in_valid_i,
  output logic               in_ready_o,
  output noc_pkg::noc_flit_t out_flit_o,
  output logic               out_valid_o,
  input  logic               out_ready_i
);

  noc_pkg::noc_flit_t                 mem_q [noc_pkg::FIFO_DEPTH];
  logic [noc_pkg::FIFO_PTR_WIDTH-1:0] wr_ptr_q;
  logic [noc_pkg::FIFO_PTR_WIDTH-1:0] rd_ptr_q;
  logic [noc_pkg::FIFO_CNT_WIDTH-1:0] count_q;
  logic                               push;
  logic                               pop;

  assign in_ready_o  = count_q != noc_pkg::FIFO_CNT_WIDTH'(noc_pkg::FIFO_DEPTH);
  assign out_valid_o = count_q != '0;
  assign out_flit_o  = mem_q[rd_ptr_q];

  assign push = in_valid_i && in_ready_o;
  assign pop  = out_valid_o && out_ready_i;

  always_ff @(posedge clk) begin
    if (push) begin
      mem_q[wr_ptr_q] <= in_flit_i;
    end
  end

  // Pointers wrap at the last entry.
  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= (wr_ptr_q == noc_pkg::FIFO_PTR_WIDTH'(noc_pkg::FIFO_DEPTH - 1)) ?
                    '0 : wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= (rd_ptr_q == noc_pkg::FIFO_PTR_WIDTH'(noc_pkg::FIFO_DEPTH - 1)) ?
                    '0 : rd_ptr_q + 1'b1;
      end
      count_q <= count_q + noc_pkg::FIFO_CNT_WIDTH'(push)
                         - noc_pkg::FIFO_CNT_WIDTH'(pop);  // Both may happen at once.
    end
  end

endmodule

// ==== hdl/noc_pkg.sv ====
package noc_pkg;

  // ##########################################################################
  // Mesh geometry and sizes.
  // ##########################################################################
  localparam int SIZE_X     = 3;
  localparam int SIZE_Y     = 3;
  localparam int NUM_NODES  = SIZE_X * SIZE_Y;  // Node index is y * SIZE_X + x.
  localparam int ID_X_WIDTH = 2;
  localparam int ID_Y_WIDTH = 2;
  localparam int DATA_WIDTH = 32;
  localparam int TAG_WIDTH  = DATA_WIDTH - 2 * (ID_X_WIDTH + ID_Y_WIDTH);

  localparam int FIFO_DEPTH     = 4;
  localparam int FIFO_PTR_WIDTH = $clog2(FIFO_DEPTH);
  localparam int FIFO_CNT_WIDTH = $clog2(FIFO_DEPTH + 1);

  localparam int NUM_PORTS      = 5;
  localparam int PORT_IDX_WIDTH = $clog2(NUM_PORTS);

  typedef logic [PORT_IDX_WIDTH-1:0] noc_port_idx_t;
  typedef logic [ID_X_WIDTH-1:0]     noc_id_x_t;
  typedef logic [ID_Y_WIDTH-1:0]     noc_id_y_t;

  // East is x+1 and north is y+1.
  localparam noc_port_idx_t PORT_LOCAL = 3'd0;
  localparam noc_port_idx_t PORT_EAST  = 3'd1;
  localparam noc_port_idx_t PORT_WEST  = 3'd2;
  localparam noc_port_idx_t PORT_NORTH = 3'd3;
  localparam noc_port_idx_t PORT_SOUTH = 3'd4;

  // ##########################################################################
  // Flit format.
  // ##########################################################################
  typedef enum logic {
    FLIT_HEADER  = 1'b0,
    FLIT_PAYLOAD = 1'b1
  } noc_flit_type_e;

  typedef struct packed {
    noc_id_x_t            dst_x;
    noc_id_y_t            dst_y;
    noc_id_x_t            src_x;
    noc_id_y_t            src_y;
    logic [TAG_WIDTH-1:0] tag;
  } noc_header_t;

  // Header view in routing and raw word elsewhere.
  typedef union packed {
    noc_header_t           header;
    logic [DATA_WIDTH-1:0] raw;
  } noc_flit_data_u;

  typedef struct packed {
    noc_flit_type_e flit_type;
    logic           tail;       // Last flit of the packet.
    noc_flit_data_u data;
  } noc_flit_t;

endpackage
